//--- Makefile
# Verilator simulation of the AXI-lite monitor testbench

VERILATOR ?= verilator
TOP       ?= axil_monitor_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axil_chan_check.sv
// Per-channel checker for valid after reset and for payload stability under stall
`timescale 1ns/10ps

module axil_chan_check #(
	parameter type payload_t = logic
) (
	input  logic     i_clk,
	input  logic     i_axi_reset_n,
	input  logic     i_valid,
	input  logic     i_ready,
	input  payload_t i_payload,
	output logic     o_reset_err,
	output logic     o_stable_err
);

	// High in the cycle right after a reset cycle
	logic     r_was_reset;
	// Previous cycle held valid without ready
	logic     r_stalled;
	// Payload seen in the previous cycle
	payload_t r_payload;

	always_ff @(posedge i_clk)
	begin
		r_was_reset <= !i_axi_reset_n;
	end

	// Stall state only counts outside of reset
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			r_stalled <= 1'b0;
		else
			r_stalled <= i_valid && !i_ready;
	end

	always_ff @(posedge i_clk)
	begin
		r_payload <= i_payload;
	end

	//////////////////////////////
	// Sticky rule flags
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_reset_err  <= 1'b0;
			o_stable_err <= 1'b0;
		end
		else
		begin
			// Valid must come up low after reset
			if (r_was_reset && i_valid)
				o_reset_err <= 1'b1;
			// A stalled beat must keep valid and payload
			if (r_stalled && (!i_valid || (i_payload != r_payload)))
				o_stable_err <= 1'b1;
		end
	end

endmodule

//--- axil_mon_macros.svh
// AXI-lite monitor macros: bus widths, counter width and timing limits
`ifndef AXIL_MON_MACROS_SVH
`define AXIL_MON_MACROS_SVH

// Bus widths of the observed link
`define AXIL_ADDR_W 28
`define AXIL_DATA_W 32
// One strobe bit per data byte
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Outstanding counter width, all ones is flagged as overflow
`define AXIL_DEPTH_W 4

// Cycles a request may wait for its ready
`define AXIL_MAX_WAIT 12
// Cycles a response may wait for its ready
`define AXIL_MAX_RSTALL 12
// Cycles from request to response
`define AXIL_MAX_DELAY 12

// Sized from the sum of the limits, so it always holds the largest limit plus one
`define AXIL_TIMER_W $clog2(`AXIL_MAX_WAIT + `AXIL_MAX_RSTALL + `AXIL_MAX_DELAY + 1)

`endif

//--- axil_mon_pkg.sv
// AXI-lite monitor types: response codes, channel payloads and violation index
`include "axil_mon_macros.svh"

package axil_mon_pkg;

	// Response codes as carried on BRESP and RRESP
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	// AW and AR carry the same payload
	typedef struct packed {
		logic [`AXIL_ADDR_W-1:0] addr;
		logic [2:0]              prot;
	} addr_payload_t;

	typedef struct packed {
		logic [`AXIL_DATA_W-1:0] data;
		logic [`AXIL_STRB_W-1:0] strb;
	} wdata_payload_t;

	typedef struct packed {
		logic [`AXIL_DATA_W-1:0] data;
		resp_e                   resp;
	} rdata_payload_t;

	typedef logic [`AXIL_DEPTH_W-1:0] count_t;

	// Bit positions in the sticky violation vector
	typedef enum logic [2:0] {
		V_RESET_VALID = 3'd0,
		V_STABLE      = 3'd1,
		V_RESP_CODE   = 3'd2,
		V_ORPHAN      = 3'd3,
		V_OVERFLOW    = 3'd4,
		V_REQ_STALL   = 3'd5,
		V_RESP_STALL  = 3'd6,
		V_DELAY       = 3'd7
	} viol_e;

	typedef logic [7:0] viol_vec_t;

endpackage

//--- axil_monitor_assertions.sv
// Bound checker for the AXI-lite monitor with a reference count model and rule properties
`timescale 1ns/10ps
`include "axil_mon_macros.svh"

module axil_monitor_assertions (
	input logic                     i_clk,
	input logic                     i_axi_reset_n,
	input logic                     i_axi_awvalid,
	input logic                     i_axi_awready,
	input logic [`AXIL_ADDR_W-1:0]  i_axi_awaddr,
	input logic [2:0]               i_axi_awprot,
	input logic                     i_axi_wvalid,
	input logic                     i_axi_wready,
	input logic                     i_axi_bvalid,
	input logic                     i_axi_bready,
	input logic [1:0]               i_axi_bresp,
	input logic                     i_axi_arvalid,
	input logic                     i_axi_arready,
	input logic                     i_axi_rvalid,
	input logic                     i_axi_rready,
	input logic [1:0]               i_axi_rresp,
	input axil_mon_pkg::count_t     o_awr_outstanding,
	input axil_mon_pkg::count_t     o_wr_outstanding,
	input axil_mon_pkg::count_t     o_rd_outstanding,
	input axil_mon_pkg::viol_vec_t  o_violations
);
	import axil_mon_pkg::*;

	int                       fail_count = 0;
	// Requests accepted minus responses accepted
	count_t                   awr_model, wr_model, rd_model;
	// Consecutive cycles of each timed condition
	logic [`AXIL_TIMER_W-1:0] ar_wait, r_hold, wr_wait, rd_wait;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			awr_model <= '0;
			wr_model  <= '0;
			rd_model  <= '0;
			ar_wait   <= '0;
			r_hold    <= '0;
			wr_wait   <= '0;
			rd_wait   <= '0;
		end
		else
		begin
			awr_model <= awr_model + count_t'(i_axi_awvalid && i_axi_awready)
				- count_t'(i_axi_bvalid && i_axi_bready);
			wr_model  <= wr_model + count_t'(i_axi_wvalid && i_axi_wready)
				- count_t'(i_axi_bvalid && i_axi_bready);
			rd_model  <= rd_model + count_t'(i_axi_arvalid && i_axi_arready)
				- count_t'(i_axi_rvalid && i_axi_rready);
			// AR waiting with no read data on the bus
			ar_wait <= (i_axi_arvalid && !i_axi_arready && !i_axi_rvalid) ? ar_wait + 1'b1 : '0;
			r_hold  <= (i_axi_rvalid && !i_axi_rready) ? r_hold + 1'b1 : '0;
			wr_wait <= ((awr_model != '0) && (wr_model != '0) && !i_axi_bvalid)
				? wr_wait + 1'b1 : '0;
			rd_wait <= ((rd_model != '0) && !i_axi_rvalid) ? rd_wait + 1'b1 : '0;
		end
	end

	//////////////////////////////
	// Counts and sticky flags
	//////////////////////////////

	a_counts: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(o_awr_outstanding == awr_model) && (o_wr_outstanding == wr_model)
		&& (o_rd_outstanding == rd_model))
		else
		begin
			fail_count++;
			$error("FAILED %0t: outstanding counts differ from the model", $time);
		end

	// No bit may fall outside reset
	a_sticky: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		$past(i_axi_reset_n) |-> ((o_violations & $past(o_violations)) == $past(o_violations)))
		else
		begin
			fail_count++;
			$error("FAILED %0t: a violation bit cleared without reset", $time);
		end

	//////////////////////////////
	// Rule flags
	//////////////////////////////

	a_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		$past(i_axi_reset_n && i_axi_awvalid && !i_axi_awready)
		&& (!i_axi_awvalid || (i_axi_awaddr != $past(i_axi_awaddr))
		|| (i_axi_awprot != $past(i_axi_awprot)))
		|=> o_violations[V_STABLE])
		else
		begin
			fail_count++;
			$error("FAILED %0t: stalled AW changed without the stability flag", $time);
		end

	a_reset_valid: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		!$past(i_axi_reset_n) && (i_axi_awvalid || i_axi_wvalid || i_axi_bvalid
		|| i_axi_arvalid || i_axi_rvalid) |=> o_violations[V_RESET_VALID])
		else
		begin
			fail_count++;
			$error("FAILED %0t: valid after reset not flagged", $time);
		end

	a_orphan: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_axi_bvalid && ((awr_model == '0) || (wr_model == '0)))
		|| (i_axi_rvalid && (rd_model == '0)) |=> o_violations[V_ORPHAN])
		else
		begin
			fail_count++;
			$error("FAILED %0t: response without request not flagged", $time);
		end

	a_resp_code: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(i_axi_bvalid && (i_axi_bresp == RESP_EXOKAY))
		|| (i_axi_rvalid && (i_axi_rresp == RESP_EXOKAY)) |=> o_violations[V_RESP_CODE])
		else
		begin
			fail_count++;
			$error("FAILED %0t: exclusive-okay response not flagged", $time);
		end

	a_overflow: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(&awr_model) || (&wr_model) || (&rd_model) |=> o_violations[V_OVERFLOW])
		else
		begin
			fail_count++;
			$error("FAILED %0t: all-ones count not flagged", $time);
		end

	//////////////////////////////
	// Timing limits
	//////////////////////////////

	a_req_stall: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(ar_wait >= `AXIL_MAX_WAIT) |=> o_violations[V_REQ_STALL])
		else
		begin
			fail_count++;
			$error("FAILED %0t: AR stall past the limit not flagged", $time);
		end

	a_resp_stall: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(r_hold >= `AXIL_MAX_RSTALL) |=> o_violations[V_RESP_STALL])
		else
		begin
			fail_count++;
			$error("FAILED %0t: R stall past the limit not flagged", $time);
		end

	a_delay: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(wr_wait >= `AXIL_MAX_DELAY) || (rd_wait >= `AXIL_MAX_DELAY)
		|=> o_violations[V_DELAY])
		else
		begin
			fail_count++;
			$error("FAILED %0t: late response not flagged", $time);
		end

endmodule

bind axil_monitor_top axil_monitor_assertions u_assert (.*);

//--- axil_monitor_tb.sv
// Testbench for the AXI-lite monitor that drives legal traffic and provokes each rule
`timescale 1ns/10ps
`include "axil_mon_macros.svh"

module axil_monitor_tb;
	import axil_mon_pkg::*;

	localparam int unsigned SEED = 32'h594c_84e2;
	localparam int FLAG_TIMEOUT  = 40;

	logic                    i_clk;
	logic                    i_axi_reset_n;
	logic                    i_axi_awvalid, i_axi_awready, i_axi_wvalid, i_axi_wready;
	logic                    i_axi_bvalid, i_axi_bready, i_axi_arvalid, i_axi_arready;
	logic                    i_axi_rvalid, i_axi_rready;
	logic [`AXIL_ADDR_W-1:0] i_axi_awaddr, i_axi_araddr;
	logic [2:0]              i_axi_awprot, i_axi_arprot;
	logic [`AXIL_DATA_W-1:0] i_axi_wdata, i_axi_rdata;
	logic [`AXIL_STRB_W-1:0] i_axi_wstrb;
	logic [1:0]              i_axi_bresp, i_axi_rresp;
	count_t                  o_awr_outstanding, o_wr_outstanding, o_rd_outstanding;
	viol_vec_t               o_violations;
	int                      errors;
	// High while only legal traffic is on the link
	logic                    legal_phase;

	axil_monitor_top DUT (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [`AXIL_ADDR_W-1:0] rand_addr();
		logic [31:0] rnd;
		rnd = $urandom;
		return rnd[`AXIL_ADDR_W-1:0];
	endfunction

	task automatic idle_inputs();
		i_axi_awvalid = 1'b0;
		i_axi_awready = 1'b0;
		i_axi_awaddr  = '0;
		i_axi_awprot  = '0;
		i_axi_wvalid  = 1'b0;
		i_axi_wready  = 1'b0;
		i_axi_wdata   = '0;
		i_axi_wstrb   = '0;
		i_axi_bvalid  = 1'b0;
		i_axi_bready  = 1'b0;
		i_axi_bresp   = RESP_OKAY;
		i_axi_arvalid = 1'b0;
		i_axi_arready = 1'b0;
		i_axi_araddr  = '0;
		i_axi_arprot  = '0;
		i_axi_rvalid  = 1'b0;
		i_axi_rready  = 1'b0;
		i_axi_rdata   = '0;
		i_axi_rresp   = RESP_OKAY;
	endtask

	// Falling edge, plus the no-violation check during legal traffic
	task automatic next_cycle();
		@(negedge i_clk);
		if (legal_phase)
			assert (o_violations == '0)
			else
			begin
				errors++;
				$display("FAILED at %0t: violations %b during legal traffic", $time, o_violations);
			end
	endtask

	// Two reset cycles, then RVALID optionally high in the first free cycle
	task automatic apply_reset(input logic rvalid_first);
		@(negedge i_clk);
		idle_inputs();
		i_axi_reset_n = 1'b0;
		repeat (2) @(negedge i_clk);
		i_axi_reset_n = 1'b1;
		i_axi_rvalid  = rvalid_first;
		@(negedge i_clk);
		i_axi_rvalid  = 1'b0;
	endtask

	task automatic wait_flag(input viol_e idx, input int limit, input string what);
		int n;
		bit seen;
		n    = 0;
		seen = o_violations[idx];
		while (!seen && (n < limit))
		begin
			next_cycle();
			seen = o_violations[idx];
			n++;
		end
		if (!seen)
		begin
			errors++;
			$display("Timeout: the %s flag was not raised within %0d cycles", what, limit);
		end
	endtask

	// Address and data accepted together in one cycle
	task automatic accept_write();
		i_axi_awvalid = 1'b1;
		i_axi_awready = 1'b1;
		i_axi_wvalid  = 1'b1;
		i_axi_wready  = 1'b1;
		next_cycle();
		i_axi_awvalid = 1'b0;
		i_axi_awready = 1'b0;
		i_axi_wvalid  = 1'b0;
		i_axi_wready  = 1'b0;
	endtask

	task automatic accept_reads(input int n);
		i_axi_arvalid = 1'b1;
		i_axi_arready = 1'b1;
		repeat (n) next_cycle();
		i_axi_arvalid = 1'b0;
		i_axi_arready = 1'b0;
	endtask

	// Write with a short random stall and a short random response latency
	task automatic write_txn();
		int          stall;
		int          lat;
		logic [31:0] rnd;
		stall = $urandom_range(0, 3);
		lat   = $urandom_range(0, 3);
		rnd   = $urandom;
		i_axi_awvalid = 1'b1;
		i_axi_wvalid  = 1'b1;
		i_axi_awaddr  = rand_addr();
		i_axi_awprot  = 3'($urandom_range(0, 7));
		i_axi_wdata   = $urandom;
		i_axi_wstrb   = rnd[`AXIL_STRB_W-1:0];
		// Payload held while the slave stalls
		repeat (stall) next_cycle();
		i_axi_awready = 1'b1;
		i_axi_wready  = 1'b1;
		next_cycle();
		i_axi_awvalid = 1'b0;
		i_axi_awready = 1'b0;
		i_axi_wvalid  = 1'b0;
		i_axi_wready  = 1'b0;
		repeat (lat) next_cycle();
		i_axi_bvalid = 1'b1;
		i_axi_bready = 1'b1;
		i_axi_bresp  = rnd[31] ? RESP_SLVERR : RESP_OKAY;
		next_cycle();
		i_axi_bvalid = 1'b0;
		i_axi_bready = 1'b0;
	endtask

	task automatic read_txn();
		int stall;
		int lat;
		stall = $urandom_range(0, 3);
		lat   = $urandom_range(0, 3);
		i_axi_arvalid = 1'b1;
		i_axi_araddr  = rand_addr();
		i_axi_arprot  = 3'($urandom_range(0, 7));
		repeat (stall) next_cycle();
		i_axi_arready = 1'b1;
		next_cycle();
		i_axi_arvalid = 1'b0;
		i_axi_arready = 1'b0;
		repeat (lat) next_cycle();
		i_axi_rvalid = 1'b1;
		i_axi_rready = 1'b1;
		i_axi_rdata  = $urandom;
		i_axi_rresp  = ($urandom_range(0, 1) == 1) ? RESP_SLVERR : RESP_OKAY;
		next_cycle();
		i_axi_rvalid = 1'b0;
		i_axi_rready = 1'b0;
	endtask

	//////////////////////////////
	// Test phases
	//////////////////////////////

	initial
	begin
		void'($urandom(SEED));
		errors        = 0;
		legal_phase   = 1'b0;
		i_axi_reset_n = 1'b0;
		idle_inputs();

		// Legal traffic, model and counts compared by the bound checker
		apply_reset(1'b0);
		legal_phase = 1'b1;
		repeat (24)
		begin
			if ($urandom_range(0, 1) == 1)
				write_txn();
			else
				read_txn();
		end
		next_cycle();
		legal_phase = 1'b0;

		// Stalled write address changes under the slave
		apply_reset(1'b0);
		i_axi_awvalid = 1'b1;
		i_axi_awaddr  = rand_addr();
		repeat (2) next_cycle();
		i_axi_awaddr  = ~i_axi_awaddr;
		wait_flag(V_STABLE, FLAG_TIMEOUT, "stability");
		repeat (3) next_cycle();
		assert (o_violations[V_STABLE])
		else
		begin
			errors++;
			$display("FAILED at %0t: stability flag dropped before reset", $time);
		end

		// Read address never accepted
		apply_reset(1'b0);
		i_axi_arvalid = 1'b1;
		i_axi_araddr  = rand_addr();
		wait_flag(V_REQ_STALL, `AXIL_MAX_WAIT + 8, "request stall");

		// Read data refused by the master
		apply_reset(1'b0);
		accept_reads(1);
		i_axi_rvalid = 1'b1;
		wait_flag(V_RESP_STALL, `AXIL_MAX_RSTALL + 8, "response stall");

		// Write accepted, response withheld
		apply_reset(1'b0);
		accept_write();
		wait_flag(V_DELAY, `AXIL_MAX_DELAY + 8, "response delay");

		// Write response with nothing outstanding
		apply_reset(1'b0);
		i_axi_bvalid = 1'b1;
		wait_flag(V_ORPHAN, FLAG_TIMEOUT, "orphan response");

		// Exclusive-okay on a read
		apply_reset(1'b0);
		accept_reads(1);
		i_axi_rvalid = 1'b1;
		i_axi_rready = 1'b1;
		i_axi_rresp  = RESP_EXOKAY;
		next_cycle();
		i_axi_rvalid = 1'b0;
		i_axi_rready = 1'b0;
		wait_flag(V_RESP_CODE, FLAG_TIMEOUT, "response code");

		// RVALID up right after reset, then reads pile up to all ones
		apply_reset(1'b1);
		wait_flag(V_RESET_VALID, FLAG_TIMEOUT, "valid after reset");
		accept_reads(15);
		wait_flag(V_OVERFLOW, FLAG_TIMEOUT, "counter overflow");
		repeat (2) next_cycle();

		$display("Error counts: %0d testbench, %0d assertion", errors, DUT.u_assert.fail_count);
		if ((errors == 0) && (DUT.u_assert.fail_count == 0))
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- axil_monitor_top.sv
// AXI-lite slave protocol monitor: counts outstanding requests and latches violations
`timescale 1ns/10ps
`include "axil_mon_macros.svh"

module axil_monitor_top (
	input  logic                     i_clk,
	input  logic                     i_axi_reset_n,
	// Write address
	input  logic                     i_axi_awvalid,
	input  logic                     i_axi_awready,
	input  logic [`AXIL_ADDR_W-1:0]  i_axi_awaddr,
	input  logic [2:0]               i_axi_awprot,
	// Write data
	input  logic                     i_axi_wvalid,
	input  logic                     i_axi_wready,
	input  logic [`AXIL_DATA_W-1:0]  i_axi_wdata,
	input  logic [`AXIL_STRB_W-1:0]  i_axi_wstrb,
	// Write response
	input  logic                     i_axi_bvalid,
	input  logic                     i_axi_bready,
	input  logic [1:0]               i_axi_bresp,
	// Read address
	input  logic                     i_axi_arvalid,
	input  logic                     i_axi_arready,
	input  logic [`AXIL_ADDR_W-1:0]  i_axi_araddr,
	input  logic [2:0]               i_axi_arprot,
	// Read data
	input  logic                     i_axi_rvalid,
	input  logic                     i_axi_rready,
	input  logic [`AXIL_DATA_W-1:0]  i_axi_rdata,
	input  logic [1:0]               i_axi_rresp,
	// Monitor state
	output axil_mon_pkg::count_t     o_awr_outstanding,
	output axil_mon_pkg::count_t     o_wr_outstanding,
	output axil_mon_pkg::count_t     o_rd_outstanding,
	output axil_mon_pkg::viol_vec_t  o_violations
);
	import axil_mon_pkg::*;

	addr_payload_t  aw_payload, ar_payload;
	wdata_payload_t w_payload;
	rdata_payload_t r_payload;
	resp_e          b_resp, r_resp;
	// Per-channel flags, order AW W B AR R
	logic [4:0]     reset_err, stable_err;
	logic           orphan_err, resp_code_err, overflow_err;
	logic           req_stall_err, resp_stall_err, delay_err;

	axil_txn_if u_txn ();

	assign b_resp     = resp_e'(i_axi_bresp);
	assign r_resp     = resp_e'(i_axi_rresp);
	assign aw_payload = '{addr: i_axi_awaddr, prot: i_axi_awprot};
	assign ar_payload = '{addr: i_axi_araddr, prot: i_axi_arprot};
	assign w_payload  = '{data: i_axi_wdata, strb: i_axi_wstrb};
	assign r_payload  = '{data: i_axi_rdata, resp: r_resp};

	//////////////////////////////
	// Channel rules
	//////////////////////////////

	axil_chan_check #(.payload_t(addr_payload_t)) u_aw_check (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_awvalid), .i_ready(i_axi_awready), .i_payload(aw_payload),
		.o_reset_err(reset_err[0]), .o_stable_err(stable_err[0])
	);
	axil_chan_check #(.payload_t(wdata_payload_t)) u_w_check (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_wvalid), .i_ready(i_axi_wready), .i_payload(w_payload),
		.o_reset_err(reset_err[1]), .o_stable_err(stable_err[1])
	);
	// B has no payload beyond its response code
	axil_chan_check #(.payload_t(resp_e)) u_b_check (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_bvalid), .i_ready(i_axi_bready), .i_payload(b_resp),
		.o_reset_err(reset_err[2]), .o_stable_err(stable_err[2])
	);
	axil_chan_check #(.payload_t(addr_payload_t)) u_ar_check (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_arvalid), .i_ready(i_axi_arready), .i_payload(ar_payload),
		.o_reset_err(reset_err[3]), .o_stable_err(stable_err[3])
	);
	axil_chan_check #(.payload_t(rdata_payload_t)) u_r_check (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_valid(i_axi_rvalid), .i_ready(i_axi_rready), .i_payload(r_payload),
		.o_reset_err(reset_err[4]), .o_stable_err(stable_err[4])
	);

	//////////////////////////////
	// Counters and timers
	//////////////////////////////

	axil_outstanding u_outstanding (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_axi_awvalid), .i_awready(i_axi_awready),
		.i_wvalid(i_axi_wvalid), .i_wready(i_axi_wready),
		.i_bvalid(i_axi_bvalid), .i_bready(i_axi_bready),
		.i_arvalid(i_axi_arvalid), .i_arready(i_axi_arready),
		.i_rvalid(i_axi_rvalid), .i_rready(i_axi_rready),
		.i_bresp(b_resp), .i_rresp(r_resp), .txn(u_txn.tracker),
		.o_awr_outstanding(o_awr_outstanding), .o_wr_outstanding(o_wr_outstanding),
		.o_rd_outstanding(o_rd_outstanding), .o_orphan_err(orphan_err),
		.o_resp_code_err(resp_code_err), .o_overflow_err(overflow_err)
	);

	axil_timing_check u_timing (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_axi_awvalid), .i_wvalid(i_axi_wvalid), .i_arvalid(i_axi_arvalid),
		.i_awready(i_axi_awready), .i_wready(i_axi_wready), .i_arready(i_axi_arready),
		.i_bvalid(i_axi_bvalid), .i_bready(i_axi_bready),
		.i_rvalid(i_axi_rvalid), .i_rready(i_axi_rready), .txn(u_txn.monitor),
		.o_req_stall_err(req_stall_err), .o_resp_stall_err(resp_stall_err),
		.o_delay_err(delay_err)
	);

	// Any channel breaking a rule sets the shared bit
	assign o_violations[V_RESET_VALID] = |reset_err;
	assign o_violations[V_STABLE]      = |stable_err;
	assign o_violations[V_RESP_CODE]   = resp_code_err;
	assign o_violations[V_ORPHAN]      = orphan_err;
	assign o_violations[V_OVERFLOW]    = overflow_err;
	assign o_violations[V_REQ_STALL]   = req_stall_err;
	assign o_violations[V_RESP_STALL]  = resp_stall_err;
	assign o_violations[V_DELAY]       = delay_err;

endmodule

//--- axil_outstanding.sv
// Outstanding transaction counters with orphan, overflow and response-code checks
`timescale 1ns/10ps

module axil_outstanding (
	input  logic                  i_clk,
	input  logic                  i_axi_reset_n,
	input  logic                  i_awvalid,
	input  logic                  i_awready,
	input  logic                  i_wvalid,
	input  logic                  i_wready,
	input  logic                  i_bvalid,
	input  logic                  i_bready,
	input  logic                  i_arvalid,
	input  logic                  i_arready,
	input  logic                  i_rvalid,
	input  logic                  i_rready,
	input  axil_mon_pkg::resp_e   i_bresp,
	input  axil_mon_pkg::resp_e   i_rresp,
	axil_txn_if.tracker           txn,
	output axil_mon_pkg::count_t  o_awr_outstanding,
	output axil_mon_pkg::count_t  o_wr_outstanding,
	output axil_mon_pkg::count_t  o_rd_outstanding,
	output logic                  o_orphan_err,
	output logic                  o_resp_code_err,
	output logic                  o_overflow_err
);
	import axil_mon_pkg::*;

	count_t r_awr_cnt;
	count_t r_wr_cnt;
	count_t r_rd_cnt;

	// Accepts only count while out of reset
	assign txn.aw_fire = i_awvalid && i_awready && i_axi_reset_n;
	assign txn.w_fire  = i_wvalid  && i_wready  && i_axi_reset_n;
	assign txn.ar_fire = i_arvalid && i_arready && i_axi_reset_n;
	assign txn.b_fire  = i_bvalid  && i_bready  && i_axi_reset_n;
	assign txn.r_fire  = i_rvalid  && i_rready  && i_axi_reset_n;

	//////////////////////////////
	// Counters
	//////////////////////////////

	// Request adds one, response removes one, both together cancel
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			r_awr_cnt <= '0;
			r_wr_cnt  <= '0;
			r_rd_cnt  <= '0;
		end
		else
		begin
			case ({txn.aw_fire, txn.b_fire})
				2'b10:   r_awr_cnt <= r_awr_cnt + 1'b1;
				2'b01:   r_awr_cnt <= r_awr_cnt - 1'b1;
				default: r_awr_cnt <= r_awr_cnt;
			endcase
			case ({txn.w_fire, txn.b_fire})
				2'b10:   r_wr_cnt <= r_wr_cnt + 1'b1;
				2'b01:   r_wr_cnt <= r_wr_cnt - 1'b1;
				default: r_wr_cnt <= r_wr_cnt;
			endcase
			case ({txn.ar_fire, txn.r_fire})
				2'b10:   r_rd_cnt <= r_rd_cnt + 1'b1;
				2'b01:   r_rd_cnt <= r_rd_cnt - 1'b1;
				default: r_rd_cnt <= r_rd_cnt;
			endcase
		end
	end

	assign txn.awr_cnt       = r_awr_cnt;
	assign txn.wr_cnt        = r_wr_cnt;
	assign txn.rd_cnt        = r_rd_cnt;
	assign o_awr_outstanding = r_awr_cnt;
	assign o_wr_outstanding  = r_wr_cnt;
	assign o_rd_outstanding  = r_rd_cnt;

	//////////////////////////////
	// Response-side flags
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_orphan_err    <= 1'b0;
			o_resp_code_err <= 1'b0;
			o_overflow_err  <= 1'b0;
		end
		else
		begin
			// A write response needs both address and data accepted
			if (i_bvalid && ((r_awr_cnt == '0) || (r_wr_cnt == '0)))
				o_orphan_err <= 1'b1;
			if (i_rvalid && (r_rd_cnt == '0))
				o_orphan_err <= 1'b1;
			// Exclusive access is not part of AXI-lite
			if ((i_bvalid && (i_bresp == RESP_EXOKAY))
					|| (i_rvalid && (i_rresp == RESP_EXOKAY)))
				o_resp_code_err <= 1'b1;
			// All ones means the next accept would wrap
			if ((&r_awr_cnt) || (&r_wr_cnt) || (&r_rd_cnt))
				o_overflow_err <= 1'b1;
		end
	end

endmodule

//--- axil_timing_check.sv
// Stall and response-delay timers with sticky limit flags
`timescale 1ns/10ps
`include "axil_mon_macros.svh"

module axil_timing_check (
	input  logic         i_clk,
	input  logic         i_axi_reset_n,
	input  logic         i_awvalid,
	input  logic         i_wvalid,
	input  logic         i_arvalid,
	input  logic         i_awready,
	input  logic         i_wready,
	input  logic         i_arready,
	input  logic         i_bvalid,
	input  logic         i_bready,
	input  logic         i_rvalid,
	input  logic         i_rready,
	axil_txn_if.monitor  txn,
	output logic         o_req_stall_err,
	output logic         o_resp_stall_err,
	output logic         o_delay_err
);
	import axil_mon_pkg::*;

	logic [`AXIL_TIMER_W-1:0] r_aw_stall, r_w_stall, r_ar_stall;
	logic [`AXIL_TIMER_W-1:0] r_b_stall, r_r_stall;
	logic [`AXIL_TIMER_W-1:0] r_wr_delay, r_rd_delay;

	//////////////////////////////
	// Request stalls
	//////////////////////////////

	// Timers restart whenever the slave has a reason to hold off
	always_ff @(posedge i_clk)
	begin
		// A pending B response may back up the write path
		if (!i_axi_reset_n || !i_awvalid || i_awready || i_bvalid)
			r_aw_stall <= '0;
		// Address ahead of data, slave may be waiting on WVALID
		else if ((txn.awr_cnt >= txn.wr_cnt) && !i_wvalid)
			r_aw_stall <= '0;
		else
			r_aw_stall <= r_aw_stall + 1'b1;

		// Mirror of the address rule
		if (!i_axi_reset_n || !i_wvalid || i_wready || i_bvalid)
			r_w_stall <= '0;
		else if ((txn.wr_cnt >= txn.awr_cnt) && !i_awvalid)
			r_w_stall <= '0;
		else
			r_w_stall <= r_w_stall + 1'b1;

		// Reads are exempt while RVALID is up
		if (!i_axi_reset_n || !i_arvalid || i_arready || i_rvalid)
			r_ar_stall <= '0;
		else
			r_ar_stall <= r_ar_stall + 1'b1;
	end

	//////////////////////////////
	// Response stalls and delays
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		// Count only while the master refuses a response
		if (!i_axi_reset_n || !i_bvalid || i_bready)
			r_b_stall <= '0;
		else
			r_b_stall <= r_b_stall + 1'b1;
		if (!i_axi_reset_n || !i_rvalid || i_rready)
			r_r_stall <= '0;
		else
			r_r_stall <= r_r_stall + 1'b1;

		// A write is complete only once both halves are in
		if (!i_axi_reset_n || i_bvalid || (txn.awr_cnt == count_t'(0))
				|| (txn.wr_cnt == count_t'(0)))
			r_wr_delay <= '0;
		else
			r_wr_delay <= r_wr_delay + 1'b1;
		if (!i_axi_reset_n || i_rvalid || (txn.rd_cnt == count_t'(0)))
			r_rd_delay <= '0;
		else
			r_rd_delay <= r_rd_delay + 1'b1;
	end

	// Flags hold until the next reset
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_req_stall_err  <= 1'b0;
			o_resp_stall_err <= 1'b0;
			o_delay_err      <= 1'b0;
		end
		else
		begin
			if ((r_aw_stall >= `AXIL_MAX_WAIT) || (r_w_stall >= `AXIL_MAX_WAIT)
					|| (r_ar_stall >= `AXIL_MAX_WAIT))
				o_req_stall_err <= 1'b1;
			if ((r_b_stall >= `AXIL_MAX_RSTALL) || (r_r_stall >= `AXIL_MAX_RSTALL))
				o_resp_stall_err <= 1'b1;
			if ((r_wr_delay >= `AXIL_MAX_DELAY) || (r_rd_delay >= `AXIL_MAX_DELAY))
				o_delay_err <= 1'b1;
		end
	end

endmodule

//--- axil_txn_if.sv
// Accept pulses and outstanding counts shared between the counter and timer blocks
`timescale 1ns/10ps

interface axil_txn_if;
	import axil_mon_pkg::*;

	// Single-cycle accept pulses, combinational
	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic b_fire;
	logic r_fire;

	// Registered outstanding counts
	count_t awr_cnt;
	count_t wr_cnt;
	count_t rd_cnt;

	// Counter block drives everything
	modport tracker (
		output aw_fire, w_fire, ar_fire, b_fire, r_fire,
		output awr_cnt, wr_cnt, rd_cnt
	);

	// Timer block only observes
	modport monitor (
		input aw_fire, w_fire, ar_fire, b_fire, r_fire,
		input awr_cnt, wr_cnt, rd_cnt
	);

endinterface

//--- compile.f
+incdir+.
axil_mon_pkg.sv
axil_txn_if.sv
axil_chan_check.sv
axil_outstanding.sv
axil_timing_check.sv
axil_monitor_top.sv
axil_monitor_assertions.sv
axil_monitor_tb.sv
